// ==== Bender.yml ====
package:
  name: oflow_registration

sources:
  - rtl/oflow_feature_pkg.sv
  - rtl/oflow_score_pkg.sv
  - rtl/oflow_match_if.sv
  - rtl/oflow_feature_latch.sv
  - rtl/oflow_feature_mem.sv
  - rtl/oflow_score_calc.sv
  - rtl/oflow_score_board.sv
  - rtl/oflow_registration.sv
  - target: test
    files:
      - test/oflow_registration_tb.sv

// ==== rtl/oflow_feature_latch.sv ====
//--------------------------------------------------------------------------
// start is taken only while busy is low, the record then stays fixed
//--------------------------------------------------------------------------

module oflow_feature_latch (
	input logic clk,
	input logic reset_N,
	input logic start_registration,
	input logic busy,
	input oflow_feature_pkg::feature_t feature_cur,
	output oflow_feature_pkg::feature_t feature_reg,
	output logic go
);

	import oflow_feature_pkg::*;

	logic take; // accepted start

	//--------------------------------------------------------------------------
	// accept
	//--------------------------------------------------------------------------

	// a second pulse during a walk is dropped here
	assign take = start_registration && !busy;

	// go lines up with the new record
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			go <= 1'b0;
		end else begin
			go <= take; // single cycle, start is a pulse
		end
	end

	//--------------------------------------------------------------------------
	// record
	//--------------------------------------------------------------------------

	// host may change its inputs after the start, walk sees this copy
	always_ff @(posedge clk) begin
		if (take) begin
			feature_reg <= feature_cur;
		end
	end

endmodule

// ==== rtl/oflow_feature_mem.sv ====
//--------------------------------------------------------------------------
// two banks of max_rows, writes past max_rows in one frame are dropped
// reads come from the previous bank one cycle after rd_row
//--------------------------------------------------------------------------

module oflow_feature_mem (
	input logic clk,
	input logic reset_N,
	input logic ready_new_frame,
	input logic [oflow_feature_pkg::row_len-1:0] rd_row,
	output oflow_feature_pkg::feature_t rd_feature,
	output logic [oflow_score_pkg::id_len-1:0] rd_id,
	output logic [oflow_feature_pkg::row_len:0] prev_count,
	input logic wr_en,
	input oflow_feature_pkg::feature_t wr_feature,
	input logic [oflow_score_pkg::id_len-1:0] wr_id
);

	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;

	feature_t feat_mem [2][max_rows]; // history records
	logic [id_len-1:0] id_mem [2][max_rows]; // ids per row
	logic [row_len:0] obj_count [2]; // objects written per bank
	logic cur_bank; // bank of the running frame
	logic prev_bank;
	logic wr_ok;

	assign prev_bank = ~cur_bank;
	assign prev_count = obj_count[prev_bank];
	assign wr_ok = wr_en && (obj_count[cur_bank] < max_rows); // bank full check

	// bank pointer and counts
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			cur_bank <= 1'b0;
			obj_count[0] <= '0;
			obj_count[1] <= '0;
		end else if (ready_new_frame) begin
			cur_bank <= prev_bank; // swap
			obj_count[prev_bank] <= '0; // old previous bank becomes current, empty
		end else if (wr_ok) begin
			obj_count[cur_bank] <= obj_count[cur_bank] + 1'b1;
		end
	end

	// storage, write row is the running count
	always_ff @(posedge clk) begin
		if (wr_ok) begin
			feat_mem[cur_bank][obj_count[cur_bank][row_len-1:0]] <= wr_feature;
			id_mem[cur_bank][obj_count[cur_bank][row_len-1:0]] <= wr_id;
		end
		rd_feature <= feat_mem[prev_bank][rd_row]; // registered read
		rd_id <= id_mem[prev_bank][rd_row];
	end

endmodule

// ==== rtl/oflow_feature_pkg.sv ====
//--------------------------------------------------------------------------
// feature record of one detected object, all fields unsigned 8 bit
// one bank holds at most max_rows objects of a frame
//--------------------------------------------------------------------------

package oflow_feature_pkg;

	//--------------------------------------------------------------------------
	// widths
	//--------------------------------------------------------------------------

	localparam int feature_len = 8; // every field of the record
	localparam int max_rows = 8; // objects per frame, rows per bank
	localparam int row_len = 3; // row index, log2(max_rows)

	//--------------------------------------------------------------------------
	// record
	//--------------------------------------------------------------------------

	// 48 bit record, pos_x in the top byte
	typedef struct packed {
		logic [feature_len-1:0] pos_x; // box position
		logic [feature_len-1:0] pos_y;
		logic [feature_len-1:0] width; // box size
		logic [feature_len-1:0] height;
		logic [feature_len-1:0] color1; // dominant colors
		logic [feature_len-1:0] color2;
	} feature_t;

	// history row count is row_len+1 bits wide, 0 .. max_rows
	// rows above that are never written

endpackage

// ==== rtl/oflow_match_if.sv ====
//--------------------------------------------------------------------------
// one matching result per registration, valid is a single cycle pulse
//--------------------------------------------------------------------------

interface oflow_match_if;

	import oflow_score_pkg::*;

	logic valid; // result ready, one cycle
	logic [score_len-1:0] score; // minimum weighted score
	logic [id_len-1:0] id; // id of best previous row
	logic found; // previous bank not empty

	// score calculator side
	modport calc (
		output valid,
		output score,
		output id,
		output found
	);

	// score board side, owns the threshold decision
	modport board (
		input valid,
		input score,
		input id,
		input found
	);

endinterface

// ==== rtl/oflow_registration.sv ====
//--------------------------------------------------------------------------
// registration top, one object in flight, starts during busy are dropped
// ready_new_frame only while busy is low
//--------------------------------------------------------------------------

module oflow_registration (
	input logic clk,
	input logic reset_N,
	input logic start_registration, // one cycle pulse
	input logic ready_new_frame, // one cycle pulse, swaps banks
	input logic [oflow_feature_pkg::feature_len-1:0] pos_x_cur,
	input logic [oflow_feature_pkg::feature_len-1:0] pos_y_cur,
	input logic [oflow_feature_pkg::feature_len-1:0] width_cur,
	input logic [oflow_feature_pkg::feature_len-1:0] height_cur,
	input logic [oflow_feature_pkg::feature_len-1:0] color1_cur,
	input logic [oflow_feature_pkg::feature_len-1:0] color2_cur,
	input logic [oflow_score_pkg::weight_len-1:0] pos_x_weight,
	input logic [oflow_score_pkg::weight_len-1:0] pos_y_weight,
	input logic [oflow_score_pkg::weight_len-1:0] width_weight,
	input logic [oflow_score_pkg::weight_len-1:0] height_weight,
	input logic [oflow_score_pkg::weight_len-1:0] color1_weight,
	input logic [oflow_score_pkg::weight_len-1:0] color2_weight,
	output logic busy,
	output logic done_registration,
	output logic [oflow_score_pkg::id_len-1:0] id_out,
	output logic [oflow_score_pkg::score_len-1:0] score_out,
	output logic new_object
);

	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;

	feature_t feature_cur; // packed host inputs
	feature_t feature_reg; // latched record
	weights_t weights;
	logic go;
	logic [row_len-1:0] rd_row;
	feature_t rd_feature;
	logic [id_len-1:0] rd_id;
	logic [row_len:0] prev_count;
	logic wr_en;
	feature_t wr_feature;
	logic [id_len-1:0] wr_id;

	oflow_match_if match_bus ();

	//--------------------------------------------------------------------------
	// packing
	//--------------------------------------------------------------------------

	assign feature_cur.pos_x = pos_x_cur;
	assign feature_cur.pos_y = pos_y_cur;
	assign feature_cur.width = width_cur;
	assign feature_cur.height = height_cur;
	assign feature_cur.color1 = color1_cur;
	assign feature_cur.color2 = color2_cur;

	assign weights.pos_x_w = pos_x_weight;
	assign weights.pos_y_w = pos_y_weight;
	assign weights.width_w = width_weight;
	assign weights.height_w = height_weight;
	assign weights.color1_w = color1_weight;
	assign weights.color2_w = color2_weight;

	// busy low again in the done cycle, so a start may follow at once
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy <= 1'b0;
		end else if (match_bus.valid) begin
			busy <= 1'b0; // done follows next cycle
		end else if (start_registration && !busy) begin
			busy <= 1'b1;
		end
	end

	//--------------------------------------------------------------------------
	// blocks
	//--------------------------------------------------------------------------

	oflow_feature_latch u_latch (
		.clk(clk), .reset_N(reset_N),
		.start_registration(start_registration), .busy(busy),
		.feature_cur(feature_cur), .feature_reg(feature_reg), .go(go)
	);

	oflow_score_calc u_calc (
		.clk(clk), .reset_N(reset_N), .go(go),
		.feature_reg(feature_reg), .weights(weights), .prev_count(prev_count),
		.rd_row(rd_row), .rd_feature(rd_feature), .rd_id(rd_id), .match(match_bus)
	);

	oflow_score_board u_board (
		.clk(clk), .reset_N(reset_N), .match(match_bus), .feature_reg(feature_reg),
		.wr_en(wr_en), .wr_feature(wr_feature), .wr_id(wr_id),
		.id_out(id_out), .score_out(score_out), .new_object(new_object),
		.done_registration(done_registration)
	);

	oflow_feature_mem u_mem (
		.clk(clk), .reset_N(reset_N), .ready_new_frame(ready_new_frame),
		.rd_row(rd_row), .rd_feature(rd_feature), .rd_id(rd_id), .prev_count(prev_count),
		.wr_en(wr_en), .wr_feature(wr_feature), .wr_id(wr_id)
	);

endmodule

// ==== rtl/oflow_score_board.sv ====
//--------------------------------------------------------------------------
// threshold decision and id issue, one result at a time
// fresh ids count up from first_id and wrap at the id width
//--------------------------------------------------------------------------

module oflow_score_board (
	input logic clk,
	input logic reset_N,
	oflow_match_if.board match,
	input oflow_feature_pkg::feature_t feature_reg,
	output logic wr_en,
	output oflow_feature_pkg::feature_t wr_feature,
	output logic [oflow_score_pkg::id_len-1:0] wr_id,
	output logic [oflow_score_pkg::id_len-1:0] id_out,
	output logic [oflow_score_pkg::score_len-1:0] score_out,
	output logic new_object,
	output logic done_registration
);

	import oflow_score_pkg::*;

	logic matched; // reuse the previous id
	logic [id_len-1:0] next_id; // next fresh id
	logic [id_len-1:0] id_sel;

	//--------------------------------------------------------------------------
	// decision
	//--------------------------------------------------------------------------

	always_comb begin
		matched = match.found && (match.score <= score_len'(match_threshold));
		id_sel = matched ? match.id : next_id;
	end

	// fresh id counter and done pulse
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			next_id <= id_len'(first_id);
			done_registration <= 1'b0;
		end else begin
			done_registration <= match.valid; // one cycle after valid
			if (match.valid && !matched) begin
				next_id <= next_id + 1'b1; // id consumed
			end
		end
	end

	//--------------------------------------------------------------------------
	// result registers
	//--------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (match.valid) begin
			id_out <= id_sel;
			score_out <= match.found ? match.score : '0; // 0 on empty bank
			new_object <= !matched;
		end
	end

	//--------------------------------------------------------------------------
	// history write
	//--------------------------------------------------------------------------

	// written in the done cycle, into the current bank
	assign wr_en = done_registration;
	assign wr_feature = feature_reg; // latch holds it until the next start
	assign wr_id = id_out;

endmodule

// ==== rtl/oflow_score_calc.sv ====
//--------------------------------------------------------------------------
// one read per cycle over the previous bank, keeps the strict minimum
// valid n+2 cycles after go for n rows, 1 cycle when the bank is empty
//--------------------------------------------------------------------------

module oflow_score_calc (
	input logic clk,
	input logic reset_N,
	input logic go,
	input oflow_feature_pkg::feature_t feature_reg,
	input oflow_score_pkg::weights_t weights,
	input logic [oflow_feature_pkg::row_len:0] prev_count,
	output logic [oflow_feature_pkg::row_len-1:0] rd_row,
	input oflow_feature_pkg::feature_t rd_feature,
	input logic [oflow_score_pkg::id_len-1:0] rd_id,
	oflow_match_if.calc match
);

	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_walk,
		st_report
	} state_t;

	state_t state;
	logic issuing; // reads still to be issued
	logic data_vld; // rd_feature holds a row this cycle
	logic last_row; // rd_row is the last row of the bank
	logic found; // at least one row compared
	logic better; // current row beats the stored minimum
	logic [score_len-1:0] score_now; // score of the returned row
	logic [score_len-1:0] min_score;
	logic [id_len-1:0] min_id;

	//--------------------------------------------------------------------------
	// scoring
	//--------------------------------------------------------------------------

	// weight times absolute difference of one field
	function automatic logic [score_len-1:0] term(
		input logic [weight_len-1:0] w,
		input logic [feature_len-1:0] a,
		input logic [feature_len-1:0] b
	);
		logic [feature_len-1:0] diff;
		diff = (a > b) ? (a - b) : (b - a);
		return score_len'(w) * score_len'(diff);
	endfunction

	// sum of six terms, 15 bits at most
	always_comb begin
		score_now = term(weights.pos_x_w, feature_reg.pos_x, rd_feature.pos_x);
		score_now += term(weights.pos_y_w, feature_reg.pos_y, rd_feature.pos_y);
		score_now += term(weights.width_w, feature_reg.width, rd_feature.width);
		score_now += term(weights.height_w, feature_reg.height, rd_feature.height);
		score_now += term(weights.color1_w, feature_reg.color1, rd_feature.color1);
		score_now += term(weights.color2_w, feature_reg.color2, rd_feature.color2);
	end

	// strictly smaller, so on a tie the lower row stays
	assign better = !found || (score_now < min_score);
	assign last_row = ({1'b0, rd_row} == (prev_count - 1'b1));

	//--------------------------------------------------------------------------
	// fsm
	//--------------------------------------------------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= st_idle;
			rd_row <= '0;
			issuing <= 1'b0;
			data_vld <= 1'b0;
			found <= 1'b0;
		end else begin
			data_vld <= issuing; // memory read latency of one
			case (state)
				st_idle: begin
					if (go) begin
						rd_row <= '0;
						found <= 1'b0;
						if (prev_count == '0) begin
							state <= st_report; // nothing to compare
						end else begin
							issuing <= 1'b1;
							state <= st_walk;
						end
					end
				end
				st_walk: begin
					if (issuing) begin
						if (last_row) issuing <= 1'b0;
						else rd_row <= rd_row + 1'b1;
					end
					if (data_vld) begin
						found <= 1'b1;
						if (!issuing) state <= st_report; // last row compared
					end
				end
				st_report: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// running minimum
	always_ff @(posedge clk) begin
		if ((state == st_walk) && data_vld && better) begin
			min_score <= score_now;
			min_id <= rd_id;
		end
	end

	//--------------------------------------------------------------------------
	// result
	//--------------------------------------------------------------------------

	assign match.valid = (state == st_report); // one cycle
	assign match.score = min_score; // raw, board decides
	assign match.id = min_id;
	assign match.found = found;

endmodule

// ==== rtl/oflow_score_pkg.sv ====
//--------------------------------------------------------------------------
// score, weight and id definitions of the matching stage
// ids wrap after 255, no retirement of old ids
//--------------------------------------------------------------------------

package oflow_score_pkg;

	localparam int weight_len = 4; // one weight, 0 .. 15
	localparam int score_len = 16; // 6 * 255 * 15 fits
	localparam int id_len = 8;

	// decision
	localparam int match_threshold = 400; // largest score still a match
	localparam int first_id = 1; // first id after reset

	// one weight per feature field, same order as the record
	typedef struct packed {
		logic [weight_len-1:0] pos_x_w;
		logic [weight_len-1:0] pos_y_w;
		logic [weight_len-1:0] width_w;
		logic [weight_len-1:0] height_w;
		logic [weight_len-1:0] color1_w;
		logic [weight_len-1:0] color2_w;
	} weights_t;

endpackage

// ==== sources.f ====
rtl/oflow_feature_pkg.sv
rtl/oflow_score_pkg.sv
rtl/oflow_match_if.sv
rtl/oflow_feature_latch.sv
rtl/oflow_feature_mem.sv
rtl/oflow_score_calc.sv
rtl/oflow_score_board.sv
rtl/oflow_registration.sv
test/oflow_registration_tb.sv

// ==== test/oflow_registration_tb.sv ====
//--------------------------------------------------------------------------
// directed tests against a model of both history banks
// random features stay in 64..191 so an all zero object is always far
//--------------------------------------------------------------------------

module oflow_registration_tb;

	import oflow_feature_pkg::*;

	localparam int reset_cycles = 16;
	localparam int num_regs = 22; // registrations over all tests
	localparam int cycle_limit = num_regs * 12 + reset_cycles + 100;

	logic clk;
	logic reset_N;
	logic start_registration;
	logic ready_new_frame;
	feature_t feat_in; // host feature inputs
	logic [23:0] w_all; // pos_x_w in the top nibble
	logic busy;
	logic done_registration;
	logic new_object;
	logic [7:0] id_out;
	logic [15:0] score_out;

	feature_t m_feat [2][8]; // model banks
	logic [7:0] m_id [2][8];
	int m_cnt [2];
	int m_cur; // model current bank
	int m_next_id;
	feature_t objs [5]; // frame 0 objects
	logic [31:0] rng;
	int errors;
	int done_count;
	int cycles;

	oflow_registration UUT (
		.clk(clk), .reset_N(reset_N), .start_registration(start_registration),
		.ready_new_frame(ready_new_frame),
		.pos_x_cur(feat_in.pos_x), .pos_y_cur(feat_in.pos_y), .width_cur(feat_in.width),
		.height_cur(feat_in.height), .color1_cur(feat_in.color1), .color2_cur(feat_in.color2),
		.pos_x_weight(w_all[23:20]), .pos_y_weight(w_all[19:16]), .width_weight(w_all[15:12]),
		.height_weight(w_all[11:8]), .color1_weight(w_all[7:4]), .color2_weight(w_all[3:0]),
		.busy(busy), .done_registration(done_registration), .id_out(id_out),
		.score_out(score_out), .new_object(new_object)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // period 8
	end

	// counts every done pulse
	always @(posedge clk) begin
		if (done_registration === 1'b1) done_count <= done_count + 1;
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, done_registration did not arrive", cycles);
		$display("Simulation FAILED");
		$finish;
	end

	//--------------------------------------------------------------------------
	// helpers
	//--------------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// weighted sum of absolute differences
	// field 0 is color2 in the low byte
	function automatic int score_of(input feature_t a, input feature_t b);
		int s;
		int d;
		s = 0;
		for (int k = 0; k < 6; k++) begin
			d = int'(a[8*k +: 8]) - int'(b[8*k +: 8]);
			s += (d < 0 ? -d : d) * int'(w_all[4*k +: 4]);
		end
		return s;
	endfunction

	// fresh random object or base moved by -3 .. +3 per field
	task automatic make_object(input feature_t base, input bit perturb, output feature_t f);
		for (int k = 0; k < 6; k++) begin
			rng = xorshift32(rng);
			if (perturb) f[8*k +: 8] = 8'(int'(base[8*k +: 8]) + int'(rng[2:0] % 3'd7) - 3);
			else f[8*k +: 8] = 8'd64 + 8'(rng[6:0]);
		end
	endtask

	task automatic report_value(input string name, input int got, input int exp);
		errors++;
		$display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
	endtask

	// nearest previous row with the 400 threshold
	// the row then goes into the model bank
	task automatic predict(input feature_t f, output int e_id, output int e_score,
		output bit e_new);
		int prev;
		int best;
		bit found;
		prev = 1 - m_cur;
		found = 0;
		best = 0;
		e_id = 0;
		for (int r = 0; r < m_cnt[prev]; r++) begin
			if (!found || score_of(f, m_feat[prev][r]) < best) begin // ties keep low row
				best = score_of(f, m_feat[prev][r]);
				e_id = m_id[prev][r];
				found = 1;
			end
		end
		e_new = !(found && best <= 400);
		if (e_new) begin
			e_id = m_next_id;
			m_next_id = (m_next_id + 1) % 256; // 8 bit ids wrap
		end
		e_score = best; // 0 when nothing found
		if (m_cnt[m_cur] < 8) begin
			m_feat[m_cur][m_cnt[m_cur]] = f;
			m_id[m_cur][m_cnt[m_cur]] = e_id;
			m_cnt[m_cur]++;
		end
	endtask

	task automatic start_object(input feature_t f);
		feat_in = f;
		start_registration = 1'b1;
		@(posedge clk);
		#1 start_registration = 1'b0;
	endtask

	// one more cycle after done so the history write lands
	task automatic finish_object(input feature_t f, output int got_id);
		int e_id;
		int e_score;
		bit e_new;
		predict(f, e_id, e_score, e_new);
		while (done_registration !== 1'b1) begin
			@(posedge clk);
			#1;
		end
		if (id_out !== 8'(e_id)) report_value("id_out", id_out, e_id);
		if (score_out !== 16'(e_score)) report_value("score_out", score_out, e_score);
		if (new_object !== e_new) report_value("new_object", new_object, e_new);
		got_id = id_out;
		@(posedge clk);
		#1;
	endtask

	task automatic register_object(input feature_t f, output int got_id);
		start_object(f);
		finish_object(f, got_id);
	endtask

	task automatic next_frame();
		ready_new_frame = 1'b1;
		@(posedge clk);
		#1 ready_new_frame = 1'b0;
		m_cur = 1 - m_cur; // same swap in the model
		m_cnt[m_cur] = 0;
	endtask

	//--------------------------------------------------------------------------
	// tests
	//--------------------------------------------------------------------------

	task automatic test_first_object();
		int got;
		if (busy !== 1'b0) report_value("busy", busy, 0);
		if (done_registration !== 1'b0) report_value("done_registration", done_registration, 0);
		make_object(objs[0], 0, objs[0]);
		register_object(objs[0], got);
		if (got != 1) report_value("id_out", got, 1);
	endtask

	task automatic test_frame0();
		int got;
		for (int i = 1; i < 5; i++) begin
			make_object(objs[i], 0, objs[i]);
			register_object(objs[i], got);
			if (got != i + 1) report_value("id_out", got, i + 1);
		end
	endtask

	task automatic test_same_shuffled();
		int got;
		int order [5];
		order = '{3, 0, 4, 1, 2};
		next_frame();
		foreach (order[i]) begin
			register_object(objs[order[i]], got);
			if (got != order[i] + 1) report_value("id_out", got, order[i] + 1);
		end
	endtask

	task automatic test_perturbed();
		int got;
		feature_t f;
		next_frame();
		w_all = 24'h826143; // mixed weights
		for (int i = 0; i < 5; i++) begin
			make_object(objs[i], 1, f);
			register_object(f, got);
		end
	endtask

	// r sits halfway between p and q so row 0 must win
	task automatic test_tie_break();
		int got;
		feature_t p;
		feature_t q;
		feature_t r;
		p = {6{8'd100}};
		q = p;
		q.pos_x = 8'd110;
		r = p;
		r.pos_x = 8'd105;
		next_frame();
		next_frame(); // empty previous bank gives p and q fresh ids
		register_object(p, got);
		register_object(q, got);
		next_frame();
		register_object(r, got);
		if (got != m_id[1-m_cur][0]) report_value("id_out", got, m_id[1-m_cur][0]);
	endtask

	task automatic test_far_object();
		int got;
		w_all = 24'h444444;
		register_object('0, got);
		if (new_object !== 1'b1) report_value("new_object", new_object, 1);
		next_frame();
		next_frame(); // previous bank now empty
		register_object(objs[2], got);
		if (new_object !== 1'b1) report_value("new_object", new_object, 1);
		if (score_out !== 16'd0) report_value("score_out", score_out, 0);
	endtask

	task automatic test_busy_start();
		int got;
		int snap;
		next_frame();
		snap = done_count;
		start_object(objs[3]);
		feat_in = objs[4]; // second start while busy
		start_registration = 1'b1;
		@(posedge clk);
		#1 start_registration = 1'b0;
		finish_object(objs[3], got);
		repeat (20) @(posedge clk);
		#1;
		if (done_count - snap != 1) begin
			errors++;
			$display("start during busy was not ignored, %0d done pulses", done_count - snap);
		end
		register_object('0, got); // ids go on from the model count
	endtask

	initial begin
		reset_N = 1'b0;
		start_registration = 1'b0;
		ready_new_frame = 1'b0;
		feat_in = '0;
		w_all = 24'h352719; // no zero weight
		rng = 32'ha6d5;
		errors = 0;
		done_count = 0;
		m_cur = 0;
		m_cnt[0] = 0;
		m_cnt[1] = 0;
		m_next_id = 1;
		repeat (reset_cycles) @(posedge clk);
		#1 reset_N = 1'b1;
		test_first_object();
		test_frame0();
		test_same_shuffled();
		test_perturbed();
		test_tie_break();
		test_far_object();
		test_busy_start();
		$display("errors: %0d, registrations: %0d", errors, done_count);
		if (errors == 0) $display("Simulation PASSED");
		else $display("Simulation FAILED");
		$finish;
	end

endmodule
